// File: Makefile
SIM      := verilator
TOP      := tb_dbg_top
FILELIST := vlog.f
FLAGS    := --binary --timing
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
PASS_MSG := TEST RESULT: PASS

# Sources named in the file list, without option lines
SOURCES  := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only if the pass line shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: src/dbg_bus_unit.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_bus_unit import dbg_pkg::*; (
  input  wire               tck_i,
  input  wire               rst_i,
  input  wire               tdi_i,
  input  wire               debug_select_i,
  input  wire               capture_dr_i,
  input  wire               shift_dr_i,
  input  wire               update_dr_i,
  input  wire [DR_LEN-1:0]  data_reg_i,
  input  wire               module_sel_i,
  input  wire [DATA_W-1:0]  bus_dat_i,
  input  wire               bus_ack_i,
  input  wire               bus_err_i,
  output logic              module_tdo_o,
  output logic              inhibit_o,
  output logic [ADDR_W-1:0] bus_adr_o,
  output logic [DATA_W-1:0] bus_dat_o,
  output logic              bus_stb_o,
  output logic              bus_we_o
);

  // Idle, waiting one cycle before strobe, strobe active
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PEND,
    ST_CYC
  } state_t;

  //////////////////////////////
  // Local signals
  //////////////////////////////

  state_t                   state_q;
  logic                     busy;
  logic                     cmd_valid;
  logic [OP_MSB-OP_LSB:0]   opcode;
  logic [DATA_W-1:0]        arg;
  logic                     set_addr;
  logic                     start_cyc;
  logic                     bus_end;
  logic                     capture_hit;

  logic [ADDR_W-1:0]        addr_q;
  logic [DATA_W-1:0]        wdata_q;
  logic                     we_q;
  logic                     done_q;
  logic                     err_q;
  logic [DATA_W-1:0]        rdata_q;
  logic [BUS_RES_LEN-1:0]   out_sr;

  //////////////////////////////
  // Command decode
  //////////////////////////////

  // Module commands only, never a select command
  assign cmd_valid = update_dr_i && module_sel_i && debug_select_i && !data_reg_i[SEL_BIT];
  assign opcode    = data_reg_i[OP_MSB:OP_LSB];
  assign arg       = data_reg_i[ARG_MSB:ARG_LSB];

  assign busy      = (state_q != ST_IDLE);
  // Address stays put while a cycle is outstanding
  assign set_addr  = cmd_valid && !busy && (opcode == OP_BUS_SETADDR);
  // Write or read, dropped when busy
  assign start_cyc = cmd_valid && !busy &&
                     ((opcode == OP_BUS_WRITE) || (opcode == OP_BUS_READ));

  // Strobe ends on ack or err
  assign bus_end     = (state_q == ST_CYC) && (bus_ack_i || bus_err_i);
  assign capture_hit = capture_dr_i && module_sel_i;

  // Hold off module reselection until the cycle ends
  assign inhibit_o = busy;

  //////////////////////////////
  // Bus cycle control
  //////////////////////////////

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q   <= ST_IDLE;
      bus_stb_o <= 1'b0;
      bus_we_o  <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (start_cyc) begin
            state_q <= ST_PEND;
          end
        end
        // Strobe one cycle after update
        ST_PEND: begin
          state_q   <= ST_CYC;
          bus_stb_o <= 1'b1;
          bus_we_o  <= we_q;
        end
        ST_CYC: begin
          if (bus_end) begin
            state_q   <= ST_IDLE;
            bus_stb_o <= 1'b0;
            bus_we_o  <= 1'b0;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // Write data and direction latched on the update edge
  always_ff @(posedge tck_i) begin
    if (start_cyc) begin
      wdata_q <= arg;
      we_q    <= (opcode == OP_BUS_WRITE);
    end
  end

  // Address register with auto-increment after each word
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      addr_q <= '0;
    end else if (set_addr) begin
      addr_q <= arg;
    end else if (bus_end) begin
      addr_q <= addr_q + ADDR_W'(4);
    end
  end

  assign bus_adr_o = addr_q;
  assign bus_dat_o = wdata_q;

  //////////////////////////////
  // Status and result
  //////////////////////////////

  // Done cleared by capture, err and data kept
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      done_q  <= 1'b0;
      err_q   <= 1'b0;
      rdata_q <= '0;
    end else if (bus_end) begin
      done_q <= 1'b1;
      err_q  <= bus_err_i;
      if (!we_q) begin
        rdata_q <= bus_dat_i;
      end
    end else if (capture_hit) begin
      done_q <= 1'b0;
    end
  end

  // Output shift register, LSB first
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      out_sr <= '0;
    end else if (capture_hit) begin
      out_sr <= {rdata_q, err_q, done_q};
    end else if (shift_dr_i && module_sel_i) begin
      out_sr <= {tdi_i, out_sr[BUS_RES_LEN-1:1]};
    end
  end

  assign module_tdo_o = out_sr[0];

endmodule

`default_nettype wire

// File: src/dbg_cpu_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_cpu_ctrl import dbg_pkg::*; (
  input  wire              tck_i,
  input  wire              rst_i,
  input  wire              tdi_i,
  input  wire              debug_select_i,
  input  wire              capture_dr_i,
  input  wire              shift_dr_i,
  input  wire              update_dr_i,
  input  wire [DR_LEN-1:0] data_reg_i,
  input  wire              module_sel_i,
  input  wire              cpu_bp_i,
  output logic             module_tdo_o,
  output logic             cpu_stall_o,
  output logic             cpu_rst_o
);

  //////////////////////////////
  // Local signals
  //////////////////////////////

  logic                   cmd_valid;
  logic [OP_MSB-OP_LSB:0] opcode;
  logic [DATA_W-1:0]      arg;
  logic                   stall_q;
  logic                   bp_q;
  logic [CPU_RES_LEN-1:0] out_sr;

  assign cmd_valid = update_dr_i && module_sel_i && debug_select_i && !data_reg_i[SEL_BIT];
  assign opcode    = data_reg_i[OP_MSB:OP_LSB];
  assign arg       = data_reg_i[ARG_MSB:ARG_LSB];

  //////////////////////////////
  // Control register
  //////////////////////////////

  // Arg bit 0 stall, bit 1 reset
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      stall_q   <= 1'b0;
      cpu_rst_o <= 1'b0;
    end else if (cmd_valid) begin
      case (opcode)
        OP_CPU_WRITE: begin
          stall_q   <= arg[0];
          cpu_rst_o <= arg[1];
        end
        // Status is captured anyway
        OP_CPU_READ: ;
        default: ;
      endcase
    end
  end

  // Breakpoint latch, set wins over a clearing write
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      bp_q <= 1'b0;
    end else if (cpu_bp_i) begin
      bp_q <= 1'b1;
    end else if (cmd_valid && (opcode == OP_CPU_WRITE) && !arg[0]) begin
      bp_q <= 1'b0;
    end
  end

  // Latched breakpoint keeps the CPU stalled
  assign cpu_stall_o = stall_q | bp_q;

  //////////////////////////////
  // Status shift register
  //////////////////////////////

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      out_sr <= '0;
    end else if (capture_dr_i && module_sel_i) begin
      out_sr <= {bp_q, cpu_rst_o, cpu_stall_o};
    end else if (shift_dr_i && module_sel_i) begin
      out_sr <= {tdi_i, out_sr[CPU_RES_LEN-1:1]};
    end
  end

  assign module_tdo_o = out_sr[0];

endmodule

`default_nettype wire

// File: src/dbg_pkg.sv
`default_nettype none

package dbg_pkg;

  //////////////////////////////
  // Data register layout
  //////////////////////////////

  // Full length of the shifted data register
  localparam int DR_LEN        = 53;
  localparam int MODULE_ID_LEN = 2;
  localparam int MAX_MODULES   = 4;

  // Module slot numbers
  localparam logic [MODULE_ID_LEN-1:0] MOD_BUS = 2'd0;
  localparam logic [MODULE_ID_LEN-1:0] MOD_CPU = 2'd1;

  // Select command marker and its module ID field
  localparam int SEL_BIT = 52;
  localparam int ID_MSB  = 51;
  localparam int ID_LSB  = 50;

  //////////////////////////////
  // Command fields
  //////////////////////////////

  localparam int OP_MSB  = 51;
  localparam int OP_LSB  = 48;
  // Address for set-address, data for a write
  localparam int ARG_MSB = 47;
  localparam int ARG_LSB = 16;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // Opcodes
  localparam logic [OP_MSB-OP_LSB:0] OP_BUS_SETADDR = 4'd1;
  localparam logic [OP_MSB-OP_LSB:0] OP_BUS_WRITE   = 4'd2;
  localparam logic [OP_MSB-OP_LSB:0] OP_BUS_READ    = 4'd3;
  localparam logic [OP_MSB-OP_LSB:0] OP_CPU_WRITE   = 4'd4;
  localparam logic [OP_MSB-OP_LSB:0] OP_CPU_READ    = 4'd5;

  //////////////////////////////
  // Result words
  //////////////////////////////

  // Bus unit {rdata[31:0], err, done}, LSB out first
  localparam int BUS_RES_LEN = 34;
  // CPU unit {bp, reset, stall}
  localparam int CPU_RES_LEN = 3;

endpackage

`default_nettype wire

// File: src/dbg_select.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_select import dbg_pkg::*; (
  input  wire               tck_i,
  input  wire               rst_i,
  input  wire               tdi_i,
  input  wire               debug_select_i,
  input  wire               shift_dr_i,
  input  wire               update_dr_i,
  input  wire               inhibit_i,
  input  wire               bus_tdo_i,
  input  wire               cpu_tdo_i,
  output logic [DR_LEN-1:0] data_reg_o,
  output logic              bus_sel_o,
  output logic              cpu_sel_o,
  output logic              tdo_o
);

  //////////////////////////////
  // Local signals
  //////////////////////////////

  logic [DR_LEN-1:0]        shift_q;
  logic [MODULE_ID_LEN-1:0] module_id_q;
  logic [MAX_MODULES-1:0]   module_sel;
  // Select command sitting in the shift register
  logic                     select_cmd;
  logic [MODULE_ID_LEN-1:0] module_id_in;

  assign select_cmd   = shift_q[SEL_BIT];
  assign module_id_in = shift_q[ID_MSB:ID_LSB];

  //////////////////////////////
  // Input shift register
  //////////////////////////////

  // TDI enters at the top, one bit per shift cycle
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      shift_q <= '0;
    end else if (debug_select_i && shift_dr_i) begin
      shift_q <= {tdi_i, shift_q[DR_LEN-1:1]};
    end
  end

  // Whole register goes to every module
  assign data_reg_o = shift_q;

  //////////////////////////////
  // Module ID register
  //////////////////////////////

  // A busy module holds the current selection
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      module_id_q <= '0;
    end else if (debug_select_i && update_dr_i && select_cmd && !inhibit_i) begin
      module_id_q <= module_id_in;
    end
  end

  // One-hot decode of the ID
  always_comb begin
    module_sel              = '0;
    module_sel[module_id_q] = 1'b1;
  end

  assign bus_sel_o = module_sel[MOD_BUS];
  assign cpu_sel_o = module_sel[MOD_CPU];

  // TDO return, empty slots read as zero
  always_comb begin
    case (module_id_q)
      MOD_BUS: tdo_o = bus_tdo_i;
      MOD_CPU: tdo_o = cpu_tdo_i;
      default: tdo_o = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: src/dbg_top.sv
`timescale 1ns/1ps
`default_nettype none

module dbg_top import dbg_pkg::*; (
  input  wire               tck_i,
  input  wire               rst_i,
  input  wire               tdi_i,
  input  wire               debug_select_i,
  input  wire               capture_dr_i,
  input  wire               shift_dr_i,
  input  wire               update_dr_i,
  input  wire [DATA_W-1:0]  bus_dat_i,
  input  wire               bus_ack_i,
  input  wire               bus_err_i,
  input  wire               cpu_bp_i,
  output logic              tdo_o,
  output logic [ADDR_W-1:0] bus_adr_o,
  output logic [DATA_W-1:0] bus_dat_o,
  output logic              bus_stb_o,
  output logic              bus_we_o,
  output logic              cpu_stall_o,
  output logic              cpu_rst_o
);

  // Shared data register and per-slot return lines
  logic [DR_LEN-1:0] data_reg;
  logic              bus_sel;
  logic              cpu_sel;
  logic              bus_tdo;
  logic              cpu_tdo;
  // Only the bus unit ever blocks reselection
  logic              bus_inhibit;

  //////////////////////////////
  // Module select
  //////////////////////////////

  dbg_select i_select (
    .tck_i          (tck_i),
    .rst_i          (rst_i),
    .tdi_i          (tdi_i),
    .debug_select_i (debug_select_i),
    .shift_dr_i     (shift_dr_i),
    .update_dr_i    (update_dr_i),
    .inhibit_i      (bus_inhibit),
    .bus_tdo_i      (bus_tdo),
    .cpu_tdo_i      (cpu_tdo),
    .data_reg_o     (data_reg),
    .bus_sel_o      (bus_sel),
    .cpu_sel_o      (cpu_sel),
    .tdo_o          (tdo_o)
  );

  //////////////////////////////
  // Debug modules
  //////////////////////////////

  // Slot 0
  dbg_bus_unit i_bus (
    .tck_i          (tck_i),
    .rst_i          (rst_i),
    .tdi_i          (tdi_i),
    .debug_select_i (debug_select_i),
    .capture_dr_i   (capture_dr_i),
    .shift_dr_i     (shift_dr_i),
    .update_dr_i    (update_dr_i),
    .data_reg_i     (data_reg),
    .module_sel_i   (bus_sel),
    .bus_dat_i      (bus_dat_i),
    .bus_ack_i      (bus_ack_i),
    .bus_err_i      (bus_err_i),
    .module_tdo_o   (bus_tdo),
    .inhibit_o      (bus_inhibit),
    .bus_adr_o      (bus_adr_o),
    .bus_dat_o      (bus_dat_o),
    .bus_stb_o      (bus_stb_o),
    .bus_we_o       (bus_we_o)
  );

  // Slot 1
  dbg_cpu_ctrl i_cpu (
    .tck_i          (tck_i),
    .rst_i          (rst_i),
    .tdi_i          (tdi_i),
    .debug_select_i (debug_select_i),
    .capture_dr_i   (capture_dr_i),
    .shift_dr_i     (shift_dr_i),
    .update_dr_i    (update_dr_i),
    .data_reg_i     (data_reg),
    .module_sel_i   (cpu_sel),
    .cpu_bp_i       (cpu_bp_i),
    .module_tdo_o   (cpu_tdo),
    .cpu_stall_o    (cpu_stall_o),
    .cpu_rst_o      (cpu_rst_o)
  );

endmodule

`default_nettype wire

// File: testbench/dbg_cases.txt
# kind  slot  arg(hex)  expected(hex)
# sel/hold: 34-bit readback, wr: err bit, rd/mem: data word, cpuwr/bp: cpu status
sel    2  00000000  000000000
sel    0  00000000  000000000
addr   0  00000020  0
wr     0  11223344  0
wr     0  a5a55a5a  0
wr     0  deadbeef  0
mem    0  00000020  11223344
mem    0  00000024  a5a55a5a
mem    0  00000028  deadbeef
addr   0  00000020  0
rd     0  00000000  11223344
rd     0  00000000  a5a55a5a
rd     0  00000000  deadbeef
hold   1  600dcafe  37ab6fbbc
mem    0  0000002c  600dcafe
sel    1  00000000  0
sel    0  00000000  37ab6fbbc
addr   0  80000010  0
wr     0  cafef00d  1
mem    0  80000010  c0de0010
sel    1  00000000  0
cpuwr  1  00000003  3
cpuwr  1  00000000  0
bp     1  00000000  5
cpuwr  1  00000000  0

// File: testbench/tb_dbg_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dbg_top import dbg_pkg::*; ();

  localparam int POLL_LIMIT = 50;
  localparam int STB_LIMIT  = 20;

  logic              tck = 1'b0;
  logic              rst;
  logic              tdi;
  logic              debug_select;
  logic              capture_dr;
  logic              shift_dr;
  logic              update_dr;
  logic [DATA_W-1:0] bus_rdat;
  logic              bus_ack;
  logic              bus_err;
  logic              cpu_bp;
  logic              tdo;
  logic [ADDR_W-1:0] bus_adr;
  logic [DATA_W-1:0] bus_wdat;
  logic              bus_stb;
  logic              bus_we;
  logic              cpu_stall;
  logic              cpu_rst;
  logic              mem_hold;

  int err_count     = 0;
  int timeout_count = 0;
  // Bus activity tallies
  int stb_cycles    = 0;
  int we_cycles     = 0;

  dbg_top i_dut (
    .tck_i          (tck),
    .rst_i          (rst),
    .tdi_i          (tdi),
    .debug_select_i (debug_select),
    .capture_dr_i   (capture_dr),
    .shift_dr_i     (shift_dr),
    .update_dr_i    (update_dr),
    .bus_dat_i      (bus_rdat),
    .bus_ack_i      (bus_ack),
    .bus_err_i      (bus_err),
    .cpu_bp_i       (cpu_bp),
    .tdo_o          (tdo),
    .bus_adr_o      (bus_adr),
    .bus_dat_o      (bus_wdat),
    .bus_stb_o      (bus_stb),
    .bus_we_o       (bus_we),
    .cpu_stall_o    (cpu_stall),
    .cpu_rst_o      (cpu_rst)
  );

  tb_mem_model i_mem (
    .tck_i  (tck),
    .rst_i  (rst),
    .hold_i (mem_hold),
    .stb_i  (bus_stb),
    .we_i   (bus_we),
    .adr_i  (bus_adr),
    .dat_i  (bus_wdat),
    .dat_o  (bus_rdat),
    .ack_o  (bus_ack),
    .err_o  (bus_err)
  );

  // 8 ns period
  always #4 tck = ~tck;

  // Counted mid-cycle where the bus is stable
  always @(negedge tck) begin
    if (bus_stb) begin
      stb_cycles <= stb_cycles + 1;
      if (bus_we) begin
        we_cycles <= we_cycles + 1;
      end
    end
  end

  //////////////////////////////
  // JTAG side tasks
  //////////////////////////////

  task automatic report_mismatch(input string what, input logic [63:0] got,
                                 input logic [63:0] expected);
    $display("ERR %0t: %s, got %0h expected %0h", $time, what, got, expected);
    err_count++;
  endtask

  // LSB first, then one update pulse
  task automatic shift_word(input logic [DR_LEN-1:0] word);
    int i;
    for (i = 0; i < DR_LEN; i++) begin
      shift_dr <= 1'b1;
      tdi      <= word[i];
      @(posedge tck);
    end
    shift_dr  <= 1'b0;
    tdi       <= 1'b0;
    update_dr <= 1'b1;
    @(posedge tck);
    update_dr <= 1'b0;
  endtask

  task automatic send_select(input logic [MODULE_ID_LEN-1:0] slot);
    logic [DR_LEN-1:0] word;
    word                = '0;
    word[SEL_BIT]       = 1'b1;
    word[ID_MSB:ID_LSB] = slot;
    shift_word(word);
  endtask

  task automatic send_command(input logic [OP_MSB-OP_LSB:0] op, input logic [DATA_W-1:0] arg);
    logic [DR_LEN-1:0] word;
    word                  = '0;
    word[OP_MSB:OP_LSB]   = op;
    word[ARG_MSB:ARG_LSB] = arg;
    shift_word(word);
  endtask

  // Capture, then sample tdo mid-cycle for each bit
  task automatic read_result(input int nbits, output logic [63:0] word);
    int i;
    word = '0;
    capture_dr <= 1'b1;
    @(posedge tck);
    capture_dr <= 1'b0;
    shift_dr   <= 1'b1;
    tdi        <= 1'b0;
    for (i = 0; i < nbits; i++) begin
      @(negedge tck);
      word[i] = tdo;
      @(posedge tck);
    end
    shift_dr <= 1'b0;
  endtask

  // Poll the done bit
  task automatic wait_bus_done(output logic [63:0] word);
    int   polls;
    logic done;
    polls = 0;
    done  = 1'b0;
    word  = '0;
    while (!done && polls < POLL_LIMIT) begin
      read_result(BUS_RES_LEN, word);
      done = word[0];
      polls++;
    end
    if (!done) begin
      $display("Timed out after %0d polls waiting for the bus unit to finish", POLL_LIMIT);
      timeout_count++;
    end
  endtask

  task automatic wait_bus_strobe();
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < STB_LIMIT) begin
      @(negedge tck);
      seen = bus_stb;
      @(posedge tck);
      cycles++;
    end
    if (!seen) begin
      $display("Timed out after %0d cycles waiting for the bus strobe", STB_LIMIT);
      timeout_count++;
    end
  endtask

  // Status bit 0 is the stall pin, bit 1 the reset pin
  task automatic check_cpu_pins(input logic [1:0] status);
    @(negedge tck);
    if (cpu_stall !== status[0]) begin
      report_mismatch("cpu_stall_o", {63'd0, cpu_stall}, {63'd0, status[0]});
    end
    if (cpu_rst !== status[1]) begin
      report_mismatch("cpu_rst_o", {63'd0, cpu_rst}, {63'd0, status[1]});
    end
    @(posedge tck);
  endtask

  //////////////////////////////
  // Case playback
  //////////////////////////////

  task automatic run_case(input string kind, input logic [31:0] slot,
                          input logic [31:0] arg, input logic [63:0] expected);
    logic [63:0] word;
    logic [31:0] mem_word;
    int          stb_before;
    int          we_before;
    if (kind == "sel") begin
      send_select(slot[MODULE_ID_LEN-1:0]);
      read_result(BUS_RES_LEN, word);
      if (word !== expected) begin
        report_mismatch("readback after select", word, expected);
      end
    end else if (kind == "addr") begin
      send_command(OP_BUS_SETADDR, arg);
    end else if (kind == "wr") begin
      send_command(OP_BUS_WRITE, arg);
      wait_bus_done(word);
      if (word[1] !== expected[0]) begin
        report_mismatch("write err bit", {63'd0, word[1]}, expected);
      end
    end else if (kind == "rd") begin
      stb_before = stb_cycles;
      we_before  = we_cycles;
      send_command(OP_BUS_READ, arg);
      wait_bus_done(word);
      if (word[1] !== 1'b0) begin
        report_mismatch("read err bit", {63'd0, word[1]}, 64'd0);
      end
      if (word[33:2] !== expected[31:0]) begin
        report_mismatch("read data", {32'd0, word[33:2]}, expected);
      end
      if (stb_cycles == stb_before) begin
        $display("No bus strobe was seen for a read command");
        err_count++;
      end
      if (we_cycles != we_before) begin
        report_mismatch("bus_we_o during read", 64'd1, 64'd0);
      end
    end else if (kind == "mem") begin
      mem_word = i_mem.mem[arg[7:2]];
      if (mem_word !== expected[31:0]) begin
        report_mismatch("memory word", {32'd0, mem_word}, expected);
      end
    end else if (kind == "hold") begin
      // Ack withheld so the write stays pending
      mem_hold <= 1'b1;
      send_command(OP_BUS_WRITE, arg);
      wait_bus_strobe();
      send_select(slot[MODULE_ID_LEN-1:0]);
      read_result(BUS_RES_LEN, word);
      if (word !== expected) begin
        report_mismatch("readback while bus busy", word, expected);
      end
      mem_hold <= 1'b0;
      wait_bus_done(word);
      if (word[1] !== 1'b0) begin
        report_mismatch("held write err bit", {63'd0, word[1]}, 64'd0);
      end
    end else if (kind == "cpuwr") begin
      send_command(OP_CPU_WRITE, arg);
      read_result(CPU_RES_LEN, word);
      if (word !== expected) begin
        report_mismatch("cpu status", word, expected);
      end
      check_cpu_pins(expected[1:0]);
    end else if (kind == "bp") begin
      cpu_bp <= 1'b1;
      @(posedge tck);
      cpu_bp <= 1'b0;
      read_result(CPU_RES_LEN, word);
      if (word !== expected) begin
        report_mismatch("cpu status after breakpoint", word, expected);
      end
      check_cpu_pins(expected[1:0]);
    end else begin
      $display("Unknown case kind %s in the case file", kind);
      err_count++;
    end
  endtask

  initial begin
    int          fd;
    int          fields;
    string       line;
    string       kind;
    logic [31:0] slot;
    logic [31:0] arg;
    logic [63:0] expected;
    rst          <= 1'b1;
    tdi          <= 1'b0;
    debug_select <= 1'b0;
    capture_dr   <= 1'b0;
    shift_dr     <= 1'b0;
    update_dr    <= 1'b0;
    cpu_bp       <= 1'b0;
    mem_hold     <= 1'b0;
    repeat (3) @(posedge tck);
    rst          <= 1'b0;
    debug_select <= 1'b1;
    @(posedge tck);

    // Idle outputs out of reset
    @(negedge tck);
    if (tdo !== 1'b0) begin
      report_mismatch("tdo_o after reset", {63'd0, tdo}, 64'd0);
    end
    if (bus_stb !== 1'b0) begin
      report_mismatch("bus_stb_o after reset", {63'd0, bus_stb}, 64'd0);
    end
    if (cpu_stall !== 1'b0) begin
      report_mismatch("cpu_stall_o after reset", {63'd0, cpu_stall}, 64'd0);
    end
    if (cpu_rst !== 1'b0) begin
      report_mismatch("cpu_rst_o after reset", {63'd0, cpu_rst}, 64'd0);
    end
    @(posedge tck);

    fd = $fopen("testbench/dbg_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the case file testbench/dbg_cases.txt");
      err_count++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        // Skip comment and blank lines
        if (line.len() > 1 && line[0] != "#") begin
          fields = $sscanf(line, "%s %h %h %h", kind, slot, arg, expected);
          if (fields == 4) begin
            run_case(kind, slot, arg, expected);
          end
        end
      end
      $fclose(fd);
    end

    $display("Finished with %0d errors and %0d timeouts", err_count, timeout_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model (
  input  wire         tck_i,
  input  wire         rst_i,
  input  wire         hold_i,
  input  wire         stb_i,
  input  wire         we_i,
  input  wire  [31:0] adr_i,
  input  wire  [31:0] dat_i,
  output logic [31:0] dat_o,
  output logic        ack_o,
  output logic        err_o
);

  logic [31:0] mem [64];
  logic [1:0]  wait_cnt;
  logic        armed;
  logic [5:0]  idx;
  integer      seed = 40;

  // Word index inside the 64-word array
  assign idx = adr_i[7:2];

  // Extra response latency, 0 to 3 cycles
  function automatic logic [1:0] pick_delay();
    logic [31:0] rnd;
    rnd = $random(seed);
    return rnd[1:0];
  endfunction

  // Each word starts out holding its own byte address
  initial begin
    for (int i = 0; i < 64; i++) begin
      mem[i] = 32'hc0de_0000 | 32'(i * 4);
    end
  end

  //////////////////////////////
  // Slave response
  //////////////////////////////

  always @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      ack_o    <= 1'b0;
      err_o    <= 1'b0;
      dat_o    <= '0;
      wait_cnt <= '0;
      armed    <= 1'b0;
    end else begin
      // Response lasts a single cycle
      ack_o <= 1'b0;
      err_o <= 1'b0;
      if (stb_i && !ack_o && !err_o) begin
        if (!armed) begin
          wait_cnt <= pick_delay();
          armed    <= 1'b1;
        end else if (wait_cnt != 2'd0) begin
          wait_cnt <= wait_cnt - 2'd1;
        end else if (!hold_i) begin
          armed <= 1'b0;
          // Upper half of the address space faults
          if (adr_i[31]) begin
            err_o <= 1'b1;
          end else begin
            ack_o <= 1'b1;
            dat_o <= mem[idx];
            if (we_i) begin
              mem[idx] <= dat_i;
            end
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: vlog.f
src/dbg_pkg.sv
src/dbg_select.sv
src/dbg_bus_unit.sv
src/dbg_cpu_ctrl.sv
src/dbg_top.sv
testbench/tb_mem_model.sv
testbench/tb_dbg_top.sv
